//--- logic/eu_consts.svh
// ---------------------------------------------------------------------
// event unit constants: sizes, widths and event vector bit positions
// ---------------------------------------------------------------------
`ifndef EU_CONSTS_SVH
`define EU_CONSTS_SVH

`define EU_NB_CORES   4
`define EU_NB_SW_EVT  8
`define EU_NB_BARR    2
`define EU_EVT_W      16
`define EU_SOC_ID_W   8
`define EU_SOC_DEPTH  4
`define EU_ARG_W      16

// event vector layout, software events sit at bits 0 to 7
`define EU_BIT_BARR   8
`define EU_BIT_SOC    10
`define EU_BIT_ACC    11
`define EU_BIT_DMA    12
`define EU_BIT_TIMER  13

`endif

//--- logic/eu_pkg.sv
// ---------------------------------------------------------------------
// event unit types: command and response ports, internal controls
// ---------------------------------------------------------------------
`default_nettype none

`include "eu_consts.svh"

package eu_pkg;

  typedef enum logic [2:0] {
    NOP         = 3'd0,
    TRIG_SW     = 3'd1,
    BARR_CFG    = 3'd2,
    BARR_ARRIVE = 3'd3,
    WAIT        = 3'd4,
    CLEAR       = 3'd5,
    POP_SOC     = 3'd6
  } eu_op_e;

  typedef struct packed {
    logic                 valid;
    eu_op_e               op;
    logic [`EU_ARG_W-1:0] arg;
  } core_cmd_t;

  typedef enum logic [1:0] {
    EVT       = 2'd0,
    SOC       = 2'd1,
    SOC_EMPTY = 2'd2
  } eu_resp_kind_e;

  typedef struct packed {
    logic                 valid;
    eu_resp_kind_e        kind;
    logic [`EU_EVT_W-1:0] data;
  } core_resp_t;

  // decode to one wake unit
  typedef struct packed {
    logic                     wait_stb;
    logic [`EU_EVT_W-1:0]     wait_mask;
    logic                     clr_stb;
    logic [`EU_EVT_W-1:0]     clr_mask;
    logic [`EU_NB_SW_EVT-1:0] sw_set;
  } core_ctl_t;

  // decode to one barrier
  typedef struct packed {
    logic                    cfg_stb;
    logic [`EU_NB_CORES-1:0] target;
    logic [`EU_NB_CORES-1:0] arrive;
  } barr_req_t;

endpackage

`default_nettype wire

//--- logic/eu_cmd_decode.sv
// ---------------------------------------------------------------------
// core command decode: registers commands and fans them out as wake
// controls, software event sets, barrier requests and pop requests
// ---------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "eu_consts.svh"

module eu_cmd_decode import eu_pkg::*; (
  input  logic                                 clk_i,
  input  logic                                 rst_i,
  input  core_cmd_t [`EU_NB_CORES-1:0]         cmd_i,
  output core_ctl_t [`EU_NB_CORES-1:0]         ctl_o,
  output barr_req_t [`EU_NB_BARR-1:0]          barr_req_o,
  output logic      [`EU_NB_CORES-1:0]         pop_req_o
);

  core_cmd_t [`EU_NB_CORES-1:0] cmd_q;

  // the rest of the unit sees each command one cycle after it is issued
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int c = 0; c < `EU_NB_CORES; c++) begin
        cmd_q[c].valid <= 1'b0;
      end
    end else begin
      cmd_q <= cmd_i;
    end
  end

  always_comb begin
    ctl_o      = '0;
    barr_req_o = '0;
    pop_req_o  = '0;
    for (int c = 0; c < `EU_NB_CORES; c++) begin
      ctl_o[c].wait_mask = cmd_q[c].arg;
      ctl_o[c].clr_mask  = cmd_q[c].arg;
    end
    for (int src = 0; src < `EU_NB_CORES; src++) begin
      if (cmd_q[src].valid) begin
        case (cmd_q[src].op)
          WAIT:    ctl_o[src].wait_stb = 1'b1;
          CLEAR:   ctl_o[src].clr_stb = 1'b1;
          POP_SOC: pop_req_o[src] = 1'b1;
          TRIG_SW: begin
            // event number in arg[2:0], target cores in arg[7:4]
            for (int dst = 0; dst < `EU_NB_CORES; dst++) begin
              if (cmd_q[src].arg[4+dst]) begin
                ctl_o[dst].sw_set[cmd_q[src].arg[2:0]] = 1'b1;
              end
            end
          end
          BARR_CFG: begin
            barr_req_o[cmd_q[src].arg[0]].cfg_stb = 1'b1;
            barr_req_o[cmd_q[src].arg[0]].target  = cmd_q[src].arg[8 +: `EU_NB_CORES];
          end
          BARR_ARRIVE: barr_req_o[cmd_q[src].arg[0]].arrive[src] = 1'b1;
          default: ;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/eu_barrier.sv
// ---------------------------------------------------------------------
// hardware barrier: collects arrivals and releases the target cores
// ---------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "eu_consts.svh"

module eu_barrier import eu_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  barr_req_t               req_i,
  output logic [`EU_NB_CORES-1:0] release_o
);

  logic [`EU_NB_CORES-1:0] target_q;
  logic [`EU_NB_CORES-1:0] arrived_q;
  logic [`EU_NB_CORES-1:0] arrived_d;
  logic                    done;

  // cores outside the target are ignored
  assign arrived_d = (arrived_q | req_i.arrive) & target_q;

  // the last arrival releases in the same cycle it is seen
  assign done = !req_i.cfg_stb && (target_q != '0) && (arrived_d == target_q);

  assign release_o = done ? target_q : '0;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      target_q  <= '0;
      arrived_q <= '0;
    end else if (req_i.cfg_stb) begin
      target_q  <= req_i.target;
      arrived_q <= '0;
    end else if (done) begin
      arrived_q <= '0;
    end else begin
      arrived_q <= arrived_d;
    end
  end

endmodule

`default_nettype wire

//--- logic/eu_soc_evt_fifo.sv
// ---------------------------------------------------------------------
// soc event queue: stores peripheral event ids, serves one pop per
// cycle to the lowest requesting core and returns a credit per pop
// ---------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "eu_consts.svh"

module eu_soc_evt_fifo (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    soc_evt_valid_i,
  input  logic [`EU_SOC_ID_W-1:0] soc_evt_id_i,
  input  logic [`EU_NB_CORES-1:0] pop_req_i,
  output logic                    soc_evt_credit_o,
  output logic                    not_empty_o,
  output logic [`EU_NB_CORES-1:0] grant_o,
  output logic [`EU_SOC_ID_W-1:0] head_id_o,
  output logic                    head_valid_o
);

  localparam int PTR_W = $clog2(`EU_SOC_DEPTH);

  logic [`EU_SOC_ID_W-1:0] mem_q [`EU_SOC_DEPTH];
  logic [PTR_W-1:0]        wr_ptr_q;
  logic [PTR_W-1:0]        rd_ptr_q;
  logic [PTR_W:0]          count_q;
  logic                    full;
  logic                    push;
  logic                    pop;
  logic [`EU_NB_CORES-1:0] grant_d;

  assign full        = (count_q == (PTR_W+1)'(`EU_SOC_DEPTH));
  assign not_empty_o = (count_q != '0);
  // credits keep the sender from pushing into a full queue
  assign push        = soc_evt_valid_i && !full;
  // isolate the lowest set request bit
  assign grant_d     = pop_req_i & (~pop_req_i + 1'b1);
  assign pop         = (pop_req_i != '0) && not_empty_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q         <= '0;
      rd_ptr_q         <= '0;
      count_q          <= '0;
      grant_o          <= '0;
      head_valid_o     <= 1'b0;
      soc_evt_credit_o <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(`EU_SOC_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(`EU_SOC_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      // an empty pop still grants, but returns no id and no credit
      grant_o          <= grant_d;
      head_valid_o     <= pop;
      soc_evt_credit_o <= pop;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= soc_evt_id_i;
    end
    if (pop) begin
      head_id_o <= mem_q[rd_ptr_q];
    end
  end

endmodule

`default_nettype wire

//--- logic/eu_core_wake.sv
// ---------------------------------------------------------------------
// per-core wake unit: sticky event buffer, wait and sleep handling,
// clock enable and response generation
// ---------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "eu_consts.svh"

module eu_core_wake import eu_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  core_ctl_t               ctl_i,
  input  logic [`EU_NB_BARR-1:0]  barr_evt_i,
  input  logic                    soc_evt_i,
  input  logic                    acc_evt_i,
  input  logic                    dma_evt_i,
  input  logic                    timer_evt_i,
  input  logic                    pop_grant_i,
  input  logic                    pop_valid_i,
  input  logic [`EU_SOC_ID_W-1:0] pop_id_i,
  output core_resp_t              resp_o,
  output logic                    clock_en_o
);

  localparam int IDX_W = $clog2(`EU_EVT_W);

  logic [`EU_EVT_W-1:0] evt_in;
  logic [`EU_EVT_W-1:0] evt_store;
  logic [`EU_EVT_W-1:0] evt_view;
  logic [`EU_EVT_W-1:0] buf_q;
  logic [`EU_EVT_W-1:0] buf_d;
  logic [`EU_EVT_W-1:0] wait_mask_q;
  logic [`EU_EVT_W-1:0] mask_eff;
  logic [`EU_EVT_W-1:0] hit;
  logic                 waiting_q;
  logic                 active;
  logic                 hit_any;
  logic [IDX_W-1:0]     hit_idx;
  logic                 resp_vld_q;
  logic [IDX_W-1:0]     resp_idx_q;

  function automatic logic [IDX_W-1:0] lowest_idx(input logic [`EU_EVT_W-1:0] vec);
    logic [IDX_W-1:0] idx;
    idx = '0;
    for (int i = `EU_EVT_W - 1; i >= 0; i--) begin
      if (vec[i]) begin
        idx = IDX_W'(i);
      end
    end
    return idx;
  endfunction

  always_comb begin
    evt_in = '0;
    evt_in[`EU_NB_SW_EVT-1:0]           = ctl_i.sw_set;
    evt_in[`EU_BIT_BARR +: `EU_NB_BARR] = barr_evt_i;
    evt_in[`EU_BIT_SOC]                 = soc_evt_i;
    evt_in[`EU_BIT_ACC]                 = acc_evt_i;
    evt_in[`EU_BIT_DMA]                 = dma_evt_i;
    evt_in[`EU_BIT_TIMER]               = timer_evt_i;
    // soc line is a level from the queue, never latched
    evt_store = evt_in;
    evt_store[`EU_BIT_SOC] = 1'b0;
  end

  assign evt_view = buf_q | evt_in;
  assign active   = ctl_i.wait_stb || waiting_q;
  assign mask_eff = ctl_i.wait_stb ? ctl_i.wait_mask : wait_mask_q;
  assign hit      = evt_view & mask_eff;
  assign hit_any  = (hit != '0);
  assign hit_idx  = lowest_idx(hit);

  always_comb begin
    buf_d = buf_q;
    if (ctl_i.clr_stb) begin
      buf_d = buf_d & ~ctl_i.clr_mask;
    end
    buf_d = buf_d | evt_store;
    // the event that ends a wait is consumed
    if (active && hit_any) begin
      buf_d[hit_idx] = 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      buf_q       <= '0;
      waiting_q   <= 1'b0;
      wait_mask_q <= '0;
      clock_en_o  <= 1'b1;
      resp_vld_q  <= 1'b0;
    end else begin
      buf_q      <= buf_d;
      resp_vld_q <= active && hit_any;
      if (active && hit_any) begin
        waiting_q  <= 1'b0;
        clock_en_o <= 1'b1;
      end else if (active) begin
        // nothing pending yet, gate the core until an event shows up
        waiting_q   <= 1'b1;
        wait_mask_q <= mask_eff;
        clock_en_o  <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (active && hit_any) begin
      resp_idx_q <= hit_idx;
    end
  end

  // pop results come straight from the queue's registered grant
  always_comb begin
    resp_o       = '0;
    resp_o.valid = resp_vld_q;
    resp_o.kind  = EVT;
    resp_o.data[IDX_W-1:0] = resp_idx_q;
    if (pop_grant_i) begin
      resp_o.valid = 1'b1;
      resp_o.kind  = pop_valid_i ? SOC : SOC_EMPTY;
      resp_o.data  = '0;
      if (pop_valid_i) begin
        resp_o.data[`EU_SOC_ID_W-1:0] = pop_id_i;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/event_unit_top.sv
// ---------------------------------------------------------------------
// event unit top: command decode, hardware barriers, soc event queue
// and one wake unit per core
// ---------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "eu_consts.svh"

module event_unit_top import eu_pkg::*; (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  core_cmd_t  [`EU_NB_CORES-1:0]       core_cmd_i,
  input  logic       [`EU_NB_CORES-1:0]       acc_events_i,
  input  logic       [`EU_NB_CORES-1:0]       dma_events_i,
  input  logic       [`EU_NB_CORES-1:0]       timer_events_i,
  input  logic                                soc_evt_valid_i,
  input  logic       [`EU_SOC_ID_W-1:0]       soc_evt_id_i,
  output core_resp_t [`EU_NB_CORES-1:0]       core_resp_o,
  output logic       [`EU_NB_CORES-1:0]       core_clock_en_o,
  output logic                                soc_evt_credit_o
);

  core_ctl_t [`EU_NB_CORES-1:0]                   ctl;
  barr_req_t [`EU_NB_BARR-1:0]                    barr_req;
  logic      [`EU_NB_CORES-1:0]                   pop_req;
  logic      [`EU_NB_CORES-1:0]                   pop_grant;
  logic      [`EU_SOC_ID_W-1:0]                   head_id;
  logic                                           head_valid;
  logic                                           soc_not_empty;
  // release lines per barrier, regrouped per core
  logic      [`EU_NB_BARR-1:0][`EU_NB_CORES-1:0]  barr_release;
  logic      [`EU_NB_CORES-1:0][`EU_NB_BARR-1:0]  barr_evt;

  eu_cmd_decode cmd_decode_i (
    .clk_i      ( clk_i      ),
    .rst_i      ( rst_i      ),
    .cmd_i      ( core_cmd_i ),
    .ctl_o      ( ctl        ),
    .barr_req_o ( barr_req   ),
    .pop_req_o  ( pop_req    )
  );

  for (genvar b = 0; b < `EU_NB_BARR; b++) begin : gen_barr
    eu_barrier barrier_i (
      .clk_i     ( clk_i           ),
      .rst_i     ( rst_i           ),
      .req_i     ( barr_req[b]     ),
      .release_o ( barr_release[b] )
    );
    for (genvar c = 0; c < `EU_NB_CORES; c++) begin : gen_transp
      assign barr_evt[c][b] = barr_release[b][c];
    end
  end

  eu_soc_evt_fifo soc_fifo_i (
    .clk_i            ( clk_i            ),
    .rst_i            ( rst_i            ),
    .soc_evt_valid_i  ( soc_evt_valid_i  ),
    .soc_evt_id_i     ( soc_evt_id_i     ),
    .pop_req_i        ( pop_req          ),
    .soc_evt_credit_o ( soc_evt_credit_o ),
    .not_empty_o      ( soc_not_empty    ),
    .grant_o          ( pop_grant        ),
    .head_id_o        ( head_id          ),
    .head_valid_o     ( head_valid       )
  );

  for (genvar c = 0; c < `EU_NB_CORES; c++) begin : gen_core
    eu_core_wake core_wake_i (
      .clk_i       ( clk_i              ),
      .rst_i       ( rst_i              ),
      .ctl_i       ( ctl[c]             ),
      .barr_evt_i  ( barr_evt[c]        ),
      .soc_evt_i   ( soc_not_empty      ),
      .acc_evt_i   ( acc_events_i[c]    ),
      .dma_evt_i   ( dma_events_i[c]    ),
      .timer_evt_i ( timer_events_i[c]  ),
      .pop_grant_i ( pop_grant[c]       ),
      .pop_valid_i ( head_valid         ),
      .pop_id_i    ( head_id            ),
      .resp_o      ( core_resp_o[c]     ),
      .clock_en_o  ( core_clock_en_o[c] )
    );
  end

endmodule

`default_nettype wire

//--- verif/event_unit_assert.sv
// ---------------------------------------------------------------------
// event unit protocol assertions, bound into the top level
// ---------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "eu_consts.svh"

module event_unit_assert import eu_pkg::*; (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  core_cmd_t [`EU_NB_CORES-1:0] core_cmd_i,
  input  logic      [`EU_NB_CORES-1:0] core_clock_en_i,
  input  logic                         soc_evt_valid_i,
  input  logic                         soc_evt_credit_i
);

  logic [`EU_NB_CORES-1:0] cmd_valid;
  // ids sent whose credit has not come back yet
  logic [2:0]              in_flight_q;

  always_comb begin
    for (int c = 0; c < `EU_NB_CORES; c++) begin
      cmd_valid[c] = core_cmd_i[c].valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      in_flight_q <= '0;
    end else begin
      case ({soc_evt_valid_i, soc_evt_credit_i})
        2'b10:   in_flight_q <= in_flight_q + 3'd1;
        2'b01:   in_flight_q <= in_flight_q - 3'd1;
        default: in_flight_q <= in_flight_q;
      endcase
    end
  end

  cmd_while_gated: assert property (@(posedge clk_i) disable iff (rst_i)
    (cmd_valid & ~core_clock_en_i) == '0)
    else $error("core issued a command while its clock was gated");

  push_into_full: assert property (@(posedge clk_i) disable iff (rst_i)
    soc_evt_valid_i |-> (in_flight_q < 3'(`EU_SOC_DEPTH)))
    else $error("soc event sent while the queue was full");

  // every id earns exactly one credit, so a credit needs an id still in flight
  credit_per_pop: assert property (@(posedge clk_i) disable iff (rst_i)
    soc_evt_credit_i |-> (in_flight_q != '0))
    else $error("soc credit returned with no event outstanding");

endmodule

`default_nettype wire

//--- verif/tb_event_unit.sv
// ---------------------------------------------------------------------
// event unit testbench: replays the vector file against the DUT and
// checks responses, clock enables, latencies and soc credits
// ---------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "eu_consts.svh"

module tb_event_unit import eu_pkg::*; ();

  localparam int NC      = `EU_NB_CORES;
  localparam int TIMEOUT = 200;

  logic                    clk_i = 1'b0;
  logic                    rst_i;
  core_cmd_t  [NC-1:0]     core_cmd;
  logic       [NC-1:0]     acc_evt;
  logic       [NC-1:0]     dma_evt;
  logic       [NC-1:0]     timer_evt;
  logic                    soc_valid;
  logic [`EU_SOC_ID_W-1:0] soc_id;
  core_resp_t [NC-1:0]     core_resp;
  logic       [NC-1:0]     clock_en;
  logic                    soc_credit;

  // response log, filled by the monitor and consumed by the driver
  core_resp_t last_resp [NC];
  int         resp_edge [NC]  = '{default: 0};
  int         resp_cnt  [NC]  = '{default: 0};
  int         taken     [NC]  = '{default: 0};
  int         cyc         = 0;
  int         credit_cnt  = 0;
  int         credit_edge = 0;
  int         sent        = 0;
  string      grp;

  always #4 clk_i = ~clk_i;

  event_unit_top dut0 (
    .clk_i            ( clk_i      ),
    .rst_i            ( rst_i      ),
    .core_cmd_i       ( core_cmd   ),
    .acc_events_i     ( acc_evt    ),
    .dma_events_i     ( dma_evt    ),
    .timer_events_i   ( timer_evt  ),
    .soc_evt_valid_i  ( soc_valid  ),
    .soc_evt_id_i     ( soc_id     ),
    .core_resp_o      ( core_resp  ),
    .core_clock_en_o  ( clock_en   ),
    .soc_evt_credit_o ( soc_credit )
  );

  bind event_unit_top event_unit_assert assert_i (
    .clk_i            ( clk_i            ),
    .rst_i            ( rst_i            ),
    .core_cmd_i       ( core_cmd_i       ),
    .core_clock_en_i  ( core_clock_en_o  ),
    .soc_evt_valid_i  ( soc_evt_valid_i  ),
    .soc_evt_credit_i ( soc_evt_credit_o )
  );

  // outputs were updated at the previous edge, so they are stable here
  always @(posedge clk_i) begin
    cyc <= cyc + 1;
    if (!rst_i) begin
      for (int c = 0; c < NC; c++) begin
        if (core_resp[c].valid) begin
          last_resp[c] <= core_resp[c];
          resp_edge[c] <= cyc;
          resp_cnt[c]  <= resp_cnt[c] + 1;
        end
      end
      if (soc_credit) begin
        credit_cnt  <= credit_cnt + 1;
        credit_edge <= cyc;
      end
    end
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_resp(input string name, input core_resp_t exp, input core_resp_t act);
    if (act !== exp) begin
      fail_run($sformatf("ERR %s expected kind=%s data=%h actual valid=%b kind=%s data=%h",
                         name, exp.kind.name(), exp.data,
                         act.valid, act.kind.name(), act.data));
    end
  endtask

  task automatic check_clock_en(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      fail_run($sformatf("ERR %s clock enable expected %b actual %b", name, exp, act));
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      fail_run($sformatf("ERR %s expected %0d actual %0d", name, exp, act));
    end
  endtask

  task automatic issue_cmd(input string name, input int c, input int op, input int arg,
                           output int edge_no);
    core_cmd_t cmd;
    cmd.valid = 1'b1;
    cmd.op    = eu_op_e'(op[2:0]);
    cmd.arg   = arg[`EU_ARG_W-1:0];
    @(posedge clk_i);
    check_clock_en({name, " awake before command"}, 1'b1, clock_en[c]);
    core_cmd[c] <= cmd;
    edge_no = cyc;
    @(posedge clk_i);
    core_cmd[c].valid <= 1'b0;
  endtask

  task automatic await_resp(input string name, input int c, output core_resp_t r,
                            output int edge_no);
    int t;
    t = 0;
    while (resp_cnt[c] == taken[c]) begin
      @(posedge clk_i);
      t++;
      if (t > TIMEOUT) begin
        fail_run($sformatf("%s timed out waiting for a response from core %0d", name, c));
      end
    end
    check_count({name, " responses"}, taken[c] + 1, resp_cnt[c]);
    taken[c]++;
    r       = last_resp[c];
    edge_no = resp_edge[c];
  endtask

  task automatic await_clock_en(input string name, input int c, input logic val);
    int t;
    t = 0;
    @(posedge clk_i);
    while (clock_en[c] !== val) begin
      @(posedge clk_i);
      t++;
      if (t > TIMEOUT) begin
        fail_run($sformatf("%s timed out waiting for clock enable %b on core %0d",
                           name, val, c));
      end
    end
  endtask

  task automatic send_soc(input string name, input int id);
    int t;
    t = 0;
    @(posedge clk_i);
    // the sender holds one credit per free queue entry
    while (`EU_SOC_DEPTH - sent + credit_cnt <= 0) begin
      @(posedge clk_i);
      t++;
      if (t > TIMEOUT) begin
        fail_run($sformatf("%s timed out waiting for a soc event credit", name));
      end
    end
    soc_valid <= 1'b1;
    soc_id    <= id[`EU_SOC_ID_W-1:0];
    sent++;
    @(posedge clk_i);
    soc_valid <= 1'b0;
  endtask

  task automatic pulse_evt(input int c, input bit timer);
    @(posedge clk_i);
    if (timer) begin
      timer_evt[c] <= 1'b1;
    end else begin
      dma_evt[c] <= 1'b1;
    end
    @(posedge clk_i);
    timer_evt[c] <= 1'b0;
    dma_evt[c]   <= 1'b0;
    repeat (3) @(posedge clk_i);
  endtask

  task automatic run_vector(input string name, input int act, input int c, input int op,
                            input int arg, input int kind, input int data);
    core_resp_t exp;
    core_resp_t got;
    int         e0;
    int         e1;
    int         cr0;
    exp       = '0;
    exp.valid = 1'b1;
    exp.kind  = eu_resp_kind_e'(kind[1:0]);
    exp.data  = data[`EU_EVT_W-1:0];
    cr0       = credit_cnt;
    case (act)
      // command answered two cycles later
      0: begin
        issue_cmd(name, c, op, arg, e0);
        await_resp(name, c, got, e1);
        check_count({name, " latency"}, 2, e1 - e0 - 1);
        check_resp(name, exp, got);
        check_count({name, " credits"}, (exp.kind == SOC) ? 1 : 0, credit_cnt - cr0);
        if (exp.kind == SOC) begin
          check_count({name, " credit cycle"}, e1, credit_edge);
        end
      end
      1: begin
        issue_cmd(name, c, op, arg, e0);
        @(posedge clk_i);
      end
      // wait with nothing pending, the core has to go to sleep
      2: begin
        issue_cmd(name, c, op, arg, e0);
        await_clock_en(name, c, 1'b0);
        check_count({name, " early response"}, taken[c], resp_cnt[c]);
      end
      3: begin
        await_resp(name, c, got, e1);
        check_resp(name, exp, got);
        @(posedge clk_i);
        check_clock_en({name, " awake after wake"}, 1'b1, clock_en[c]);
      end
      4: send_soc(name, arg);
      5: pulse_evt(c, 1'b1);
      6: pulse_evt(c, 1'b0);
      7: begin
        @(posedge clk_i);
        check_clock_en(name, data[0], clock_en[c]);
      end
      default: fail_run($sformatf("%s has an unknown action %0d", name, act));
    endcase
  endtask

  initial begin
    int    fd;
    int    lineno;
    int    n;
    int    fld [6];
    string line;
    string name;
    void'($urandom(30));
    rst_i     = 1'b1;
    core_cmd  = '0;
    acc_evt   = '0;
    dma_evt   = '0;
    timer_evt = '0;
    soc_valid = 1'b0;
    soc_id    = '0;
    grp       = "none";
    repeat (4) @(posedge clk_i);
    rst_i <= 1'b0;
    // idle after reset, all cores awake and nothing answers
    repeat (4) @(posedge clk_i);
    for (int k = 0; k < NC; k++) begin
      check_clock_en($sformatf("reset core %0d", k), 1'b1, clock_en[k]);
      check_count($sformatf("reset responses core %0d", k), 0, resp_cnt[k]);
    end
    check_count("reset credits", 0, credit_cnt);
    fd = $fopen("verif/event_unit_vectors.txt", "r");
    if (fd == 0) begin
      fail_run("cannot open the vector file verif/event_unit_vectors.txt");
    end
    lineno = 0;
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      lineno++;
      if (line.len() > 0 && line[0] == "@") begin
        n = $sscanf(line, "@ %s", grp);
      end else if (line.len() > 0 && line[0] != "#") begin
        n = $sscanf(line, "%h %h %h %h %h %h", fld[0], fld[1], fld[2], fld[3], fld[4], fld[5]);
        if (n == 6) begin
          name = $sformatf("%s line %0d", grp, lineno);
          run_vector(name, fld[0], fld[1], fld[2], fld[3], fld[4], fld[5]);
          repeat ($urandom_range(3, 0)) @(posedge clk_i);
        end
      end
    end
    $fclose(fd);
    repeat (4) @(posedge clk_i);
    for (int k = 0; k < NC; k++) begin
      check_count($sformatf("unexpected responses core %0d", k), taken[k], resp_cnt[k]);
    end
    check_count("credits returned", sent, credit_cnt);
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/event_unit_vectors.txt
# columns in hex: action core opcode argument resp_kind resp_data
# action 0 cmd+resp, 1 cmd, 2 sleeping wait, 3 await wake, 4 soc send,
# 5 timer pulse, 6 dma pulse, 7 clock enable equals resp_data
@ software_events
1 0 1 0063 0 0000
0 1 4 0008 0 0003
0 2 4 0008 0 0003
2 1 4 0008 0 0003
2 2 4 0008 0 0003
1 0 1 0063 0 0000
3 1 0 0000 0 0003
3 2 0 0000 0 0003
@ barrier
1 0 2 0901 0 0000
1 0 3 0001 0 0000
2 0 4 0200 0 0009
7 0 0 0000 0 0000
1 3 3 0001 0 0000
3 0 0 0000 0 0009
0 3 4 0200 0 0009
@ soc_queue
4 0 0 00a1 0 0000
4 0 0 00b2 0 0000
4 0 0 00c3 0 0000
4 0 0 00d4 0 0000
0 1 6 0000 1 00a1
0 2 6 0000 1 00b2
0 1 6 0000 1 00c3
0 3 6 0000 1 00d4
0 0 6 0000 2 0000
@ sleep_wake
2 2 4 2000 0 000d
6 2 0 0000 0 0000
7 2 0 0000 0 0000
5 2 0 0000 0 0000
3 2 0 0000 0 000d
5 2 0 0000 0 0000
1 2 5 2000 0 0000
2 2 4 2000 0 000d
5 2 0 0000 0 0000
3 2 0 0000 0 000d

//--- files.f
+incdir+logic
logic/eu_pkg.sv
logic/eu_cmd_decode.sv
logic/eu_barrier.sv
logic/eu_soc_evt_fifo.sv
logic/eu_core_wake.sv
logic/event_unit_top.sv
verif/event_unit_assert.sv
verif/tb_event_unit.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_event_unit
FILELIST  := files.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS := $(wildcard logic/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -qx "Testbench passed" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
